// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_de_stage
FLIST     ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= all tests passed
FAIL_MSG  ?= tests failed

SOURCES := $(wildcard design/*.sv design/*.svh sim/*.sv) sim/de_stim.txt

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/de_consts.svh
`ifndef DE_CONSTS_SVH
`define DE_CONSTS_SVH

// widths fixed by RV32I
`define DE_XLEN      32
`define DE_INST_W    32
`define DE_REG_COUNT 32
`define DE_REG_IDX_W 5

// major opcodes, inst[6:0]
`define DE_OPC_OP     7'b0110011
`define DE_OPC_IMM    7'b0010011
`define DE_OPC_LUI    7'b0110111
`define DE_OPC_AUIPC  7'b0010111
`define DE_OPC_LOAD   7'b0000011
`define DE_OPC_STORE  7'b0100011
`define DE_OPC_JAL    7'b1101111
`define DE_OPC_JALR   7'b1100111
`define DE_OPC_BRANCH 7'b1100011

// funct3, inst[14:12]
// alu ops share these between register and immediate forms
`define DE_F3_ADD  3'b000
`define DE_F3_SLL  3'b001
`define DE_F3_SLT  3'b010
`define DE_F3_SLTU 3'b011
`define DE_F3_XOR  3'b100
`define DE_F3_SRL  3'b101
`define DE_F3_OR   3'b110
`define DE_F3_AND  3'b111
`define DE_F3_MUL  3'b000
`define DE_F3_LW   3'b010
`define DE_F3_SW   3'b010
`define DE_F3_JALR 3'b000
`define DE_F3_BEQ  3'b000
`define DE_F3_BNE  3'b001
`define DE_F3_BLT  3'b100
`define DE_F3_BGE  3'b101
`define DE_F3_BLTU 3'b110
`define DE_F3_BGEU 3'b111

// funct7, inst[31:25]
`define DE_F7_BASE   7'b0000000
`define DE_F7_ALT    7'b0100000 // sub, sra, srai
`define DE_F7_MULDIV 7'b0000001

`endif

// File: design/de_latch.sv
`timescale 1ns/1ps

module de_latch
  import de_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       in_valid,
  input  logic       stall,
  input  logic       flush,
  decode_if.latch    dec,
  input  addr_t      pc,
  input  word_t      rs1_val,
  input  word_t      rs2_val,
  input  word_t      imm,
  output logic       out_valid,
  output op_t        out_op,
  output addr_t      out_pc,
  output word_t      out_rs1_val,
  output word_t      out_rs2_val,
  output word_t      out_imm,
  output reg_idx_t   out_rd,
  output logic       out_wr_reg
);

  logic accept;

  // a taken branch in execute kills whatever decode holds this cycle
  assign accept = in_valid && !stall && !flush;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      out_valid   <= 1'b0;
      out_op      <= op_invalid;
      out_pc      <= '0;
      out_rs1_val <= '0;
      out_rs2_val <= '0;
      out_imm     <= '0;
      out_rd      <= '0;
      out_wr_reg  <= 1'b0;
    end else if (accept) begin
      out_valid   <= 1'b1;
      out_op      <= dec.op;
      out_pc      <= pc;
      out_rs1_val <= rs1_val;
      out_rs2_val <= rs2_val;
      out_imm     <= imm;
      out_rd      <= dec.rd;
      out_wr_reg  <= dec.wr_reg;
    end else begin
      // bubble into execute
      out_valid   <= 1'b0;
      out_op      <= op_invalid;
      out_pc      <= '0;
      out_rs1_val <= '0;
      out_rs2_val <= '0;
      out_imm     <= '0;
      out_rd      <= '0;
      out_wr_reg  <= 1'b0;
    end
  end

endmodule

// File: design/de_pkg.sv
`include "de_consts.svh"

package de_pkg;

  typedef logic [`DE_XLEN-1:0]      word_t;    // register / operand value
  typedef logic [`DE_XLEN-1:0]      addr_t;    // program counter
  typedef logic [`DE_INST_W-1:0]    inst_t;    // raw fetched instruction
  typedef logic [`DE_REG_IDX_W-1:0] reg_idx_t; // architectural register number

  // internal operation code
  // op_invalid sits at zero so a cleared latch reads as no operation
  typedef enum logic [5:0] {
    op_invalid = 6'd0,
    op_add, op_sub, op_and, op_or, op_xor,
    op_slt, op_sltu, op_sra, op_srl, op_sll,
    op_mul,
    op_addi, op_andi, op_ori, op_xori,
    op_slti, op_sltiu, op_srai, op_srli, op_slli,
    op_lui, op_auipc,
    op_lw, op_sw,
    op_jal, op_jalr,
    op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu
  } op_t;

  // which instruction fields make up the immediate
  typedef enum logic [2:0] {
    imm_none  = 3'd0,
    imm_i     = 3'd1,
    imm_s     = 3'd2,
    imm_b     = 3'd3,
    imm_u     = 3'd4,
    imm_j     = 3'd5,
    imm_shamt = 3'd6
  } imm_kind_t;

endpackage

// File: design/de_stage.sv
`timescale 1ns/1ps

module de_stage
  import de_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  // instruction issue from fetch
  input  logic     in_valid,
  input  inst_t    inst,
  input  addr_t    pc,
  // register write-back
  input  logic     wb_wr,
  input  reg_idx_t wb_rd,
  input  word_t    wb_data,
  // destinations still in flight
  input  logic     agex_wr,
  input  reg_idx_t agex_rd,
  input  logic     mem_wr,
  input  reg_idx_t mem_rd,
  input  logic     flush,
  output logic     stall,
  // decode/execute latch
  output logic     out_valid,
  output op_t      out_op,
  output addr_t    out_pc,
  output word_t    out_rs1_val,
  output word_t    out_rs2_val,
  output word_t    out_imm,
  output reg_idx_t out_rd,
  output logic     out_wr_reg
);

  word_t imm;
  word_t rs1_val;
  word_t rs2_val;

  decode_if dec ();

  instr_decoder u_decoder (
    .inst (inst),
    .dec  (dec.decoder)
  );

  imm_gen u_imm_gen (
    .inst (inst),
    .dec  (dec.imm_user),
    .imm  (imm)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .reset   (reset),
    .rs1     (dec.rs1),
    .rs2     (dec.rs2),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .wr      (wb_wr),
    .wr_idx  (wb_rd),
    .wr_data (wb_data)
  );

  hazard_unit u_hazard (
    .dec     (dec.hazard),
    .agex_wr (agex_wr),
    .agex_rd (agex_rd),
    .mem_wr  (mem_wr),
    .mem_rd  (mem_rd),
    .wb_wr   (wb_wr),
    .wb_rd   (wb_rd),
    .stall   (stall)
  );

  de_latch u_latch (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .stall       (stall),
    .flush       (flush),
    .dec         (dec.latch),
    .pc          (pc),
    .rs1_val     (rs1_val),
    .rs2_val     (rs2_val),
    .imm         (imm),
    .out_valid   (out_valid),
    .out_op      (out_op),
    .out_pc      (out_pc),
    .out_rs1_val (out_rs1_val),
    .out_rs2_val (out_rs2_val),
    .out_imm     (out_imm),
    .out_rd      (out_rd),
    .out_wr_reg  (out_wr_reg)
  );

endmodule

// File: design/decode_if.sv
`timescale 1ns/1ps

interface decode_if
  import de_pkg::*;
();

  op_t       op;
  imm_kind_t imm_kind;
  reg_idx_t  rs1;
  reg_idx_t  rs2;
  reg_idx_t  rd;
  logic      rs1_used;
  logic      rs2_used;
  logic      wr_reg;   // instruction writes rd

  modport decoder (
    output op, imm_kind, rs1, rs2, rd, rs1_used, rs2_used, wr_reg
  );

  modport imm_user (input imm_kind);

  modport hazard (input rs1, rs2, rs1_used, rs2_used);

  modport latch (input op, rd, wr_reg);

endinterface

// File: design/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
  import de_pkg::*;
(
  decode_if.hazard dec,
  input  logic     agex_wr,
  input  reg_idx_t agex_rd,
  input  logic     mem_wr,
  input  reg_idx_t mem_rd,
  input  logic     wb_wr,
  input  reg_idx_t wb_rd,
  output logic     stall
);

  logic rs1_hit;
  logic rs2_hit;

  // true when a later stage is about to write src
  function automatic logic pending_write(
    reg_idx_t src,
    logic     a_wr,
    reg_idx_t a_rd,
    logic     m_wr,
    reg_idx_t m_rd,
    logic     w_wr,
    reg_idx_t w_rd
  );
    return (a_wr && (a_rd == src)) || (m_wr && (m_rd == src)) || (w_wr && (w_rd == src));
  endfunction

  // x0 never creates a dependency
  assign rs1_hit = dec.rs1_used && (dec.rs1 != '0) &&
                   pending_write(dec.rs1, agex_wr, agex_rd, mem_wr, mem_rd, wb_wr, wb_rd);
  assign rs2_hit = dec.rs2_used && (dec.rs2 != '0) &&
                   pending_write(dec.rs2, agex_wr, agex_rd, mem_wr, mem_rd, wb_wr, wb_rd);

  assign stall = rs1_hit || rs2_hit; // combinational feedback to fetch

endmodule

// File: design/imm_gen.sv
`timescale 1ns/1ps

module imm_gen
  import de_pkg::*;
(
  input  inst_t      inst,
  decode_if.imm_user dec,
  output word_t      imm
);

  // bit 31 is the sign for every signed format
  always_comb begin
    case (dec.imm_kind)
      imm_i:
        imm = {{20{inst[31]}}, inst[31:20]};
      imm_s:
        imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      imm_b: // offset in halfwords, bit 0 always clear
        imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      imm_u:
        imm = {inst[31:12], 12'b0};
      imm_j:
        imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      imm_shamt:
        imm = {27'b0, inst[24:20]}; // shift amount, unsigned
      default:
        imm = '0;
    endcase
  end

endmodule

// File: design/instr_decoder.sv
`timescale 1ns/1ps
`include "de_consts.svh"

module instr_decoder
  import de_pkg::*;
(
  input  inst_t     inst,
  decode_if.decoder dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  op_t        op;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // register fields sit at fixed positions in every format
  assign dec.rs1 = inst[19:15];
  assign dec.rs2 = inst[24:20];
  assign dec.rd  = inst[11:7];
  assign dec.op  = op;

  always_comb begin
    op = op_invalid; // anything unmatched, csr and system included
    case (opcode)
      `DE_OPC_OP:
        case ({funct7, funct3})
          {`DE_F7_BASE, `DE_F3_ADD}:   op = op_add;
          {`DE_F7_ALT, `DE_F3_ADD}:    op = op_sub;
          {`DE_F7_BASE, `DE_F3_AND}:   op = op_and;
          {`DE_F7_BASE, `DE_F3_OR}:    op = op_or;
          {`DE_F7_BASE, `DE_F3_XOR}:   op = op_xor;
          {`DE_F7_BASE, `DE_F3_SLT}:   op = op_slt;
          {`DE_F7_BASE, `DE_F3_SLTU}:  op = op_sltu;
          {`DE_F7_ALT, `DE_F3_SRL}:    op = op_sra;
          {`DE_F7_BASE, `DE_F3_SRL}:   op = op_srl;
          {`DE_F7_BASE, `DE_F3_SLL}:   op = op_sll;
          {`DE_F7_MULDIV, `DE_F3_MUL}: op = op_mul;
          default:                     op = op_invalid;
        endcase
      `DE_OPC_IMM:
        case (funct3)
          `DE_F3_ADD:  op = op_addi;
          `DE_F3_AND:  op = op_andi;
          `DE_F3_OR:   op = op_ori;
          `DE_F3_XOR:  op = op_xori;
          `DE_F3_SLT:  op = op_slti;
          `DE_F3_SLTU: op = op_sltiu;
          `DE_F3_SLL:  op = (funct7 == `DE_F7_BASE) ? op_slli : op_invalid;
          `DE_F3_SRL: begin
            if (funct7 == `DE_F7_BASE)
              op = op_srli;
            else if (funct7 == `DE_F7_ALT)
              op = op_srai;
          end
          default:     op = op_invalid;
        endcase
      `DE_OPC_LUI:   op = op_lui;
      `DE_OPC_AUIPC: op = op_auipc;
      `DE_OPC_LOAD:  op = (funct3 == `DE_F3_LW) ? op_lw : op_invalid;
      `DE_OPC_STORE: op = (funct3 == `DE_F3_SW) ? op_sw : op_invalid;
      `DE_OPC_JAL:   op = op_jal;
      `DE_OPC_JALR:  op = (funct3 == `DE_F3_JALR) ? op_jalr : op_invalid;
      `DE_OPC_BRANCH:
        case (funct3)
          `DE_F3_BEQ:  op = op_beq;
          `DE_F3_BNE:  op = op_bne;
          `DE_F3_BLT:  op = op_blt;
          `DE_F3_BGE:  op = op_bge;
          `DE_F3_BLTU: op = op_bltu;
          `DE_F3_BGEU: op = op_bgeu;
          default:     op = op_invalid;
        endcase
      default: op = op_invalid;
    endcase
  end

  // operand use, immediate format and write-back per operation
  always_comb begin
    dec.imm_kind = imm_none;
    dec.rs1_used = 1'b0;
    dec.rs2_used = 1'b0;
    dec.wr_reg   = 1'b0;
    case (op)
      op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sltu,
      op_sra, op_srl, op_sll, op_mul: begin
        dec.rs1_used = 1'b1;
        dec.rs2_used = 1'b1;
        dec.wr_reg   = 1'b1;
      end
      op_addi, op_andi, op_ori, op_xori, op_slti, op_sltiu, op_lw, op_jalr: begin
        dec.imm_kind = imm_i;
        dec.rs1_used = 1'b1;
        dec.wr_reg   = 1'b1;
      end
      op_srai, op_srli, op_slli: begin
        dec.imm_kind = imm_shamt;
        dec.rs1_used = 1'b1;
        dec.wr_reg   = 1'b1;
      end
      op_lui, op_auipc: begin
        dec.imm_kind = imm_u;
        dec.wr_reg   = 1'b1;
      end
      op_jal: begin
        dec.imm_kind = imm_j;
        dec.wr_reg   = 1'b1;
      end
      op_sw: begin
        dec.imm_kind = imm_s;
        dec.rs1_used = 1'b1;
        dec.rs2_used = 1'b1;
      end
      op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
        dec.imm_kind = imm_b;
        dec.rs1_used = 1'b1;
        dec.rs2_used = 1'b1;
      end
      default: ; // invalid reads and writes nothing
    endcase
  end

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps
`include "de_consts.svh"

module reg_file
  import de_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_val,
  output word_t    rs2_val,
  input  logic     wr,
  input  reg_idx_t wr_idx,
  input  word_t    wr_data
);

  word_t regs [`DE_REG_COUNT];

  // read ports are combinational, a same-cycle write shows up after the edge
  assign rs1_val = regs[rs1];
  assign rs2_val = regs[rs2];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `DE_REG_COUNT; i++)
        regs[i] <= '0;
    end else if (wr && (wr_idx != '0)) begin // x0 stays zero
      regs[wr_idx] <= wr_data;
    end
  end

endmodule

// File: sim/de_stage_sva.sv
`timescale 1ns/1ps

module de_stage_sva (
  input logic clk,
  input logic reset,
  input logic stall,
  input logic flush,
  input logic out_valid,
  input logic out_wr_reg
);

  // a stalled or flushed cycle leaves a bubble in execute
  assert property (@(posedge clk) disable iff (reset) (flush || stall) |=> !out_valid)
    else $error("out_valid high one cycle after flush or stall");

  assert property (@(posedge clk) disable iff (reset) out_wr_reg |-> out_valid)
    else $error("out_wr_reg high without out_valid");

  assert property (@(posedge clk) reset |-> !out_valid)
    else $error("out_valid high during reset");

endmodule

bind de_stage de_stage_sva u_sva (
  .clk        (clk),
  .reset      (reset),
  .stall      (stall),
  .flush      (flush),
  .out_valid  (out_valid),
  .out_wr_reg (out_wr_reg)
);

// File: sim/de_stim.txt
# i: valid inst flush agex_wr agex_rd mem_wr mem_rd wb_wr wb_rd wb_data, then expected
#    stall out_valid op rd wr_reg rs1_val rs2_val imm ; w: rd data (write-back, bubble out)
# register file reads zero after reset
i 1 01ef82b3 0 0 00 0 00 0 00 00000000 0 1 01 05 1 00000000 00000000 00000000
i 1 40018333 0 0 00 0 00 0 00 00000000 0 1 02 06 1 00000000 00000000 00000000
# fill registers, the x0 write must be dropped
w 01 11111111
w 02 80000000
w 03 12345678
w 00 deadbeef
w 1f cafef00d
# add, sub, addi, sw, beq, lui, jal, srai and a csr encoding
i 1 00208233 0 0 00 0 00 0 00 00000000 0 1 01 04 1 11111111 80000000 00000000
i 1 40018333 0 0 00 0 00 0 00 00000000 0 1 02 06 1 12345678 00000000 00000000
i 1 ffb08393 0 0 00 0 00 0 00 00000000 0 1 0c 07 1 11111111 00000000 fffffffb
i 1 fe3fa623 0 0 00 0 00 0 00 00000000 0 1 18 0c 0 cafef00d 12345678 ffffffec
i 1 fe208ce3 0 0 00 0 00 0 00 00000000 0 1 1b 19 0 11111111 80000000 fffffff8
i 1 abcde437 0 0 00 0 00 0 00 00000000 0 1 15 08 1 00000000 00000000 abcde000
i 1 ffdff0ef 0 0 00 0 00 0 00 00000000 0 1 19 01 1 cafef00d 00000000 fffffffc
i 1 40415493 0 0 00 0 00 0 00 00000000 0 1 12 09 1 80000000 00000000 00000004
i 1 300022f3 0 0 00 0 00 0 00 00000000 0 1 00 05 0 00000000 00000000 00000000
# hazards against agex, mem and wb, then with in_valid low
i 1 00208233 0 1 01 0 00 0 00 00000000 1 0 00 00 0 00000000 00000000 00000000
i 1 00208233 0 0 00 1 02 0 00 00000000 1 0 00 00 0 00000000 00000000 00000000
i 1 00208233 0 0 00 0 00 1 02 80000000 1 0 00 00 0 00000000 00000000 00000000
i 0 00208233 0 1 02 0 00 0 00 00000000 1 0 00 00 0 00000000 00000000 00000000
# no stall for an unused rs2, for x0 and for inactive write flags
i 1 ffb08393 0 1 1b 0 00 0 00 00000000 0 1 0c 07 1 11111111 00000000 fffffffb
i 1 40018333 0 1 00 1 00 0 00 00000000 0 1 02 06 1 12345678 00000000 00000000
i 1 00208233 0 0 01 0 02 0 01 00000000 0 1 01 04 1 11111111 80000000 00000000
# flush and idle
i 1 00208233 1 0 00 0 00 0 00 00000000 0 0 00 00 0 00000000 00000000 00000000
i 0 00208233 0 0 00 0 00 0 00 00000000 0 0 00 00 0 00000000 00000000 00000000
# back-to-back issue
i 1 0101a503 0 0 00 0 00 0 00 00000000 0 1 17 0a 1 12345678 00000000 00000010
i 1 fe3fa623 0 0 00 0 00 0 00 00000000 0 1 18 0c 0 cafef00d 12345678 ffffffec
i 1 00208233 0 0 00 0 00 0 00 00000000 0 1 01 04 1 11111111 80000000 00000000
i 1 40415493 0 0 00 0 00 0 00 00000000 0 1 12 09 1 80000000 00000000 00000004

// File: sim/tb_de_stage.sv
`timescale 1ns/1ps

module tb_de_stage
  import de_pkg::*;
();

  // one stimulus line with the outputs expected after its edge
  typedef struct {
    logic       valid;
    inst_t      inst;
    logic       flush;
    logic       agex_wr;
    reg_idx_t   agex_rd;
    logic       mem_wr;
    reg_idx_t   mem_rd;
    logic       wb_wr;
    reg_idx_t   wb_rd;
    word_t      wb_data;
    logic       x_stall;
    logic       x_valid;
    logic [5:0] x_op;
    reg_idx_t   x_rd;
    logic       x_wr_reg;
    word_t      x_rs1;
    word_t      x_rs2;
    word_t      x_imm;
  } vector_t;

  logic     clk;
  logic     reset;
  logic     in_valid;
  inst_t    inst;
  addr_t    pc;
  logic     wb_wr;
  reg_idx_t wb_rd;
  word_t    wb_data;
  logic     agex_wr;
  reg_idx_t agex_rd;
  logic     mem_wr;
  reg_idx_t mem_rd;
  logic     flush;
  logic     stall;
  logic     out_valid;
  op_t      out_op;
  addr_t    out_pc;
  word_t    out_rs1_val;
  word_t    out_rs2_val;
  word_t    out_imm;
  reg_idx_t out_rd;
  logic     out_wr_reg;

  vector_t vecs[$];
  int      seed;
  int      cycles;
  int      limit;
  int      cur_vec;
  int      err_word;
  int      err_op;
  int      err_idx;
  int      err_bit;
  int      err_file;

  de_stage UUT (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .inst        (inst),
    .pc          (pc),
    .wb_wr       (wb_wr),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .agex_wr     (agex_wr),
    .agex_rd     (agex_rd),
    .mem_wr      (mem_wr),
    .mem_rd      (mem_rd),
    .flush       (flush),
    .stall       (stall),
    .out_valid   (out_valid),
    .out_op      (out_op),
    .out_pc      (out_pc),
    .out_rs1_val (out_rs1_val),
    .out_rs2_val (out_rs2_val),
    .out_imm     (out_imm),
    .out_rd      (out_rd),
    .out_wr_reg  (out_wr_reg)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // cycle counter that ends a stuck run
  always @(posedge clk) begin
    cycles++;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout: run still going after %0d cycles", limit);
      $display("tests failed");
      $finish;
    end
  end

  task automatic compare_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h (vector %0d)", name, got, exp, cur_vec);
      err_word++;
    end
  endtask

  task automatic compare_op(string name, op_t got, op_t exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h (vector %0d)", name, got, exp, cur_vec);
      err_op++;
    end
  endtask

  task automatic compare_idx(string name, reg_idx_t got, reg_idx_t exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h (vector %0d)", name, got, exp, cur_vec);
      err_idx++;
    end
  endtask

  task automatic compare_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h (vector %0d)", name, got, exp, cur_vec);
      err_bit++;
    end
  endtask

  task automatic read_vectors();
    int      fd;
    int      n;
    logic    done;
    string   kind;
    string   rest;
    vector_t v;
    fd = $fopen("sim/de_stim.txt", "r");
    done = 1'b0;
    if (fd == 0) begin
      $display("could not open the stimulus file sim/de_stim.txt");
      err_file++;
    end else begin
      while (!done) begin
        v = '{default: '0};
        n = $fscanf(fd, "%s", kind);
        if (n != 1) begin
          done = 1'b1; // end of file
        end else if (kind == "#") begin
          n = $fgets(rest, fd);
        end else if (kind == "w") begin
          v.wb_wr = 1'b1; // write-back only so the latch gets a bubble
          n = $fscanf(fd, "%h %h", v.wb_rd, v.wb_data);
          if (n != 2) begin
            $display("a write line in the stimulus file has missing fields");
            err_file++;
          end
          vecs.push_back(v);
        end else if (kind == "i") begin
          n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", v.valid, v.inst, v.flush,
                      v.agex_wr, v.agex_rd, v.mem_wr, v.mem_rd, v.wb_wr, v.wb_rd, v.wb_data);
          n += $fscanf(fd, "%h %h %h %h %h %h %h %h", v.x_stall, v.x_valid, v.x_op,
                       v.x_rd, v.x_wr_reg, v.x_rs1, v.x_rs2, v.x_imm);
          if (n != 18) begin
            $display("an issue line in the stimulus file has missing fields");
            err_file++;
          end
          vecs.push_back(v);
        end else begin
          $display("unknown line kind %s in the stimulus file", kind);
          err_file++;
          done = 1'b1;
        end
      end
      $fclose(fd);
    end
    if (vecs.size() == 0) begin
      $display("no vectors were read from the stimulus file");
      err_file++;
    end
  endtask

  task automatic drive_inputs(vector_t v, addr_t v_pc);
    in_valid <= v.valid;
    inst     <= v.inst;
    pc       <= v_pc;
    flush    <= v.flush;
    agex_wr  <= v.agex_wr;
    agex_rd  <= v.agex_rd;
    mem_wr   <= v.mem_wr;
    mem_rd   <= v.mem_rd;
    wb_wr    <= v.wb_wr;
    wb_rd    <= v.wb_rd;
    wb_data  <= v.wb_data;
  endtask

  task automatic check_outputs(vector_t v, addr_t exp_pc);
    compare_bit("out_valid", out_valid, v.x_valid);
    compare_op("out_op", out_op, op_t'(v.x_op));
    compare_word("out_pc", out_pc, exp_pc);
    compare_word("out_rs1_val", out_rs1_val, v.x_rs1);
    compare_word("out_rs2_val", out_rs2_val, v.x_rs2);
    compare_word("out_imm", out_imm, v.x_imm);
    compare_idx("out_rd", out_rd, v.x_rd);
    compare_bit("out_wr_reg", out_wr_reg, v.x_wr_reg);
  endtask

  initial begin
    vector_t prev;
    vector_t cur;
    vector_t idle;
    addr_t   prev_pc;
    addr_t   pc_val;
    int      total;
    seed     = 59;
    cycles   = 0;
    limit    = 0;
    cur_vec  = -1;
    err_word = 0;
    err_op   = 0;
    err_idx  = 0;
    err_bit  = 0;
    err_file = 0;
    reset    = 1'b1;
    in_valid = 1'b0;
    inst     = '0;
    pc       = '0;
    wb_wr    = 1'b0;
    wb_rd    = '0;
    wb_data  = '0;
    agex_wr  = 1'b0;
    agex_rd  = '0;
    mem_wr   = 1'b0;
    mem_rd   = '0;
    flush    = 1'b0;
    idle     = '{default: '0};
    read_vectors();
    limit = vecs.size() * 4 + 50;

    repeat (8) @(posedge clk);
    reset <= 1'b0;
    prev    = idle; // idle cycle after reset must show a bubble
    prev_pc = '0;

    foreach (vecs[i]) begin
      cur    = vecs[i];
      pc_val = $random(seed);
      @(posedge clk);
      drive_inputs(cur, pc_val);
      @(negedge clk);
      check_outputs(prev, prev_pc); // result of the previous line's edge
      cur_vec = i;
      compare_bit("stall", stall, cur.x_stall);
      prev    = cur;
      prev_pc = cur.x_valid ? pc_val : '0;
    end

    @(posedge clk);
    drive_inputs(idle, '0);
    @(negedge clk);
    check_outputs(prev, prev_pc);

    total = err_word + err_op + err_idx + err_bit + err_file;
    $display("errors: word %0d, op %0d, idx %0d, bit %0d, file %0d",
             err_word, err_op, err_idx, err_bit, err_file);
    if (total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+design
design/de_pkg.sv
design/decode_if.sv
design/instr_decoder.sv
design/imm_gen.sv
design/reg_file.sv
design/hazard_unit.sv
design/de_latch.sv
design/de_stage.sv
sim/de_stage_sva.sv
sim/tb_de_stage.sv
